// File: acq_channel.sv
module acq_channel #(
    parameter int MAX_PRE_LEN  = 4,
    parameter int MAX_POST_LEN = 4
) (
    input  logic                          ACLK,
    input  logic                          ARESET,
    input  logic                          set_config,
    input  logic                          stop,
    input  logic                          acquire_mode,
    input  acq_pkg::rfdc_data_t           h_data,
    input  logic                          h_valid,
    input  acq_pkg::lgain_data_t          l_data,
    input  logic                          l_valid,
    input  acq_pkg::rfdc_data_t           dsp_data,
    input  logic                          dsp_valid,
    input  acq_pkg::timestamp_t           timestamp,
    input  acq_pkg::sample_t              rising_threshold,
    input  acq_pkg::sample_t              falling_threshold,
    input  acq_pkg::sample_t              h_baseline,
    input  acq_pkg::sample_t              l_baseline,
    input  logic [$clog2(MAX_PRE_LEN):0]  pre_len,
    input  logic [$clog2(MAX_POST_LEN):0] post_len,
    output acq_pkg::event_word_t          event_data,
    output logic                          event_valid,
    output acq_pkg::charge_t              charge,
    output logic                          charge_valid
);
    import acq_pkg::*;

    // high-gain copy aligned with the event words
    rfdc_data_t h_gain_data;

    data_trigger #(
        .MAX_PRE_LEN  (MAX_PRE_LEN),
        .MAX_POST_LEN (MAX_POST_LEN)
    ) data_trigger_inst (
        .*
    );

    charge_sum charge_sum_inst (
        .ACLK         (ACLK),
        .ARESET       (ARESET),
        .h_gain_data  (h_gain_data),
        .event_valid  (event_valid),
        .charge       (charge),
        .charge_valid (charge_valid)
    );

endmodule

// File: acq_channel_asserts.sv
module acq_channel_asserts (
    input logic ACLK,
    input logic ARESET,
    input logic set_config,
    input logic event_valid,
    input logic charge_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // both outputs are quiet right after a reset or a new configuration
    assert property (@(posedge ACLK)
        (ARESET || set_config) |=> (!event_valid && !charge_valid))
        else $error("event_valid or charge_valid high after reset or set_config");

    // the charge report is a single-cycle pulse
    assert property (@(posedge ACLK) disable iff (ARESET)
        charge_valid |=> !charge_valid)
        else $error("charge_valid longer than one cycle");

    // the charge report follows one cycle after the end of each window
    assert property (@(posedge ACLK) disable iff (ARESET)
        $fell(event_valid) |=> charge_valid)
        else $error("charge_valid missing after event_valid fell");

endmodule

bind acq_channel acq_channel_asserts asserts_inst (.*);

// File: acq_channel_stimulus.txt
# C mode pre post rise fall h_baseline l_baseline | T stops the core
# S name dsp lg0 lg1 sat | E name words first_record (records counted since last E)
C 0 2 3 1000 500 -1000 100
S normal 0 200 300 0
S normal 0 200 300 0
S normal 0 200 300 0
S normal 0 200 300 0
S normal 0 200 300 0
S normal 0 200 300 0
S normal 0 200 300 0
S normal 0 200 300 0
S normal 2000 210 310 0
E normal 6 6
S hyst 0 200 300 0
S hyst 0 200 300 0
S hyst 0 200 300 0
S hyst 0 200 300 0
S hyst 2000 200 300 0
S hyst 700 200 300 0
S hyst 2000 200 300 0
E hyst 6 2
S retrig 0 200 300 0
S retrig 0 200 300 0
S retrig 0 200 300 0
S retrig 0 200 300 0
S retrig 2000 200 300 0
S retrig 0 200 300 0
S retrig 2000 200 300 0
E retrig 8 2
S sat 0 220 330 0
S sat 0 220 330 0
S sat 0 220 330 0
S sat 0 220 330 0
S sat 2000 400 500 1
E sat 6 2
C 1 2 3 1000 500 -1000 100
S comb 0 150 250 0
S comb 0 150 250 0
S comb 0 150 250 0
S comb 0 150 250 0
S comb 0 150 250 0
S comb 0 150 250 0
S comb 0 150 250 0
S comb 0 150 250 0
S comb 2000 -40 900 0
E comb 6 6
C 0 1 2 1500 800 -900 50
S stopped 0 60 70 0
S stopped 0 60 70 0
S stopped 0 60 70 0
S stopped 0 60 70 0
S stopped 0 60 70 0
S stopped 0 60 70 0
S stopped 0 60 70 0
S stopped 0 60 70 0
T
S stopped 3000 60 70 0
S stopped 0 60 70 0
S stopped 3000 60 70 0
E stopped 0 0
C 0 3 1 1500 800 -900 50
S reconf 0 60 70 0
S reconf 0 60 70 0
S reconf 0 60 70 0
S reconf 0 60 70 0
S reconf 0 60 70 0
S reconf 0 60 70 0
S reconf 1400 60 70 0
S reconf 0 60 70 0
S reconf 1600 60 70 0
E reconf 5 5

// File: acq_pkg.sv
package acq_pkg;

    // lane geometry of the sample streams
    localparam int SAMPLE_WIDTH          = 16;
    localparam int SAMPLES_PER_CLK       = 8;
    localparam int LGAIN_SAMPLES_PER_CLK = 2;

    // adc codes sit left-justified in each 16-bit lane
    localparam int ADC_RESOLUTION = 14;

    // tag at the head of each half of a combined word
    localparam logic [SAMPLE_WIDTH-1:0] COMBINED_MARKER = 16'hCC00;

    // info byte bit that marks the normal format
    localparam int INFO_NORMAL_BIT = 4;

    typedef logic [SAMPLE_WIDTH-1:0]                         sample_t;
    typedef logic [SAMPLES_PER_CLK*SAMPLE_WIDTH-1:0]         rfdc_data_t;
    typedef logic [LGAIN_SAMPLES_PER_CLK*SAMPLE_WIDTH-1:0]   lgain_data_t;
    typedef logic [47:0]                                     timestamp_t;
    typedef logic [7:0]                                      trig_info_t;

    // rising threshold in the upper half, falling threshold in the lower half
    typedef logic [2*SAMPLE_WIDTH-1:0]                       trig_config_t;

    // data, info, timestamp, config from msb down
    typedef logic [$bits(rfdc_data_t)+$bits(trig_info_t)
                   +$bits(timestamp_t)+$bits(trig_config_t)-1:0] event_word_t;

    typedef logic [31:0]                                     charge_t;

    typedef enum logic [1:0] {
        HOLDOFF,
        ARMED,
        FIRED,
        STOPPED
    } core_state_t;

endpackage

// File: charge_sum.sv
module charge_sum (
    input  logic                ACLK,
    input  logic                ARESET,
    input  acq_pkg::rfdc_data_t h_gain_data,
    input  logic                event_valid,
    output acq_pkg::charge_t    charge,
    output logic                charge_valid
);
    import acq_pkg::*;

    localparam int L1_N = SAMPLES_PER_CLK / 2;
    localparam int L2_N = SAMPLES_PER_CLK / 4;

    logic signed [SAMPLE_WIDTH:0]   sum_l1 [L1_N];
    logic signed [SAMPLE_WIDTH+1:0] sum_l2 [L2_N];
    logic signed [SAMPLE_WIDTH+2:0] word_sum;
    charge_t                        acc;
    logic                           valid_q;

    // adder tree, each level one bit wider than the one below
    always_comb begin
        for (int i = 0; i < L1_N; i++) begin
            sum_l1[i] = $signed(h_gain_data[(2*i)*SAMPLE_WIDTH +: SAMPLE_WIDTH])
                      + $signed(h_gain_data[(2*i+1)*SAMPLE_WIDTH +: SAMPLE_WIDTH]);
        end
        for (int i = 0; i < L2_N; i++) begin
            sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
        end
        word_sum = sum_l2[0] + sum_l2[1];
    end

    // accumulator restarts on the first valid word of a window
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            valid_q      <= 1'b0;
            charge_valid <= 1'b0;
            acc          <= '0;
        end else begin
            valid_q      <= event_valid;
            charge_valid <= valid_q & ~event_valid;
            if (event_valid) begin
                acc <= (valid_q ? acc : '0) + charge_t'(word_sum);
            end
        end
    end

    // total is latched in the first cycle after the window
    always_ff @(posedge ACLK) begin
        if (valid_q && !event_valid) begin
            charge <= acc;
        end
    end

endmodule

// File: data_trigger.sv
module data_trigger #(
    parameter int MAX_PRE_LEN  = 4,
    parameter int MAX_POST_LEN = 4
) (
    input  logic                          ACLK,
    input  logic                          ARESET,
    input  logic                          set_config,
    input  logic                          stop,
    input  logic                          acquire_mode,
    input  acq_pkg::rfdc_data_t           h_data,
    input  logic                          h_valid,
    input  acq_pkg::lgain_data_t          l_data,
    input  logic                          l_valid,
    input  acq_pkg::rfdc_data_t           dsp_data,
    input  logic                          dsp_valid,
    input  acq_pkg::timestamp_t           timestamp,
    input  acq_pkg::sample_t              rising_threshold,
    input  acq_pkg::sample_t              falling_threshold,
    input  acq_pkg::sample_t              h_baseline,
    input  acq_pkg::sample_t              l_baseline,
    input  logic [$clog2(MAX_PRE_LEN):0]  pre_len,
    input  logic [$clog2(MAX_POST_LEN):0] post_len,
    output acq_pkg::event_word_t          event_data,
    output logic                          event_valid,
    output acq_pkg::rfdc_data_t           h_gain_data
);
    import acq_pkg::*;

    localparam int PRE_W         = $clog2(MAX_PRE_LEN) + 1;
    localparam int POST_W        = $clog2(MAX_POST_LEN) + 1;
    // latency of trigger_core from input word to its trigger decision
    localparam int CORE_DATA_LAT = 3;
    localparam int CORE_CLR_LAT  = 2;
    localparam int SAT_DW        = $clog2(MAX_PRE_LEN + 1);
    localparam int CLR_DW        = $clog2(MAX_PRE_LEN + CORE_CLR_LAT + 1);
    localparam int DATA_DW       = $clog2(MAX_PRE_LEN + CORE_DATA_LAT + 1);
    localparam int HALF_W        = $bits(rfdc_data_t) / LGAIN_SAMPLES_PER_CLK;

    logic              cfg_acquire_mode;
    logic [PRE_W-1:0]  cfg_pre_len;
    logic [POST_W-1:0] cfg_post_len;
    sample_t           cfg_rising;
    sample_t           cfg_falling;
    sample_t           cfg_h_baseline;
    sample_t           cfg_l_baseline;
    trig_config_t      trig_config;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            cfg_acquire_mode <= 1'b0;
            cfg_pre_len      <= PRE_W'(1);
            cfg_post_len     <= POST_W'(1);
            cfg_rising       <= sample_t'(1024);
            cfg_falling      <= sample_t'(1024);
            cfg_h_baseline   <= sample_t'(-1024);
            cfg_l_baseline   <= sample_t'(128);
        end else if (set_config) begin
            cfg_acquire_mode <= acquire_mode;
            cfg_pre_len      <= pre_len;
            cfg_post_len     <= post_len;
            cfg_rising       <= rising_threshold;
            cfg_falling      <= falling_threshold;
            cfg_h_baseline   <= h_baseline;
            cfg_l_baseline   <= l_baseline;
        end
    end

    assign trig_config = {cfg_rising, cfg_falling};

    sample_t    h_sub    [SAMPLES_PER_CLK];
    sample_t    pair_avg [SAMPLES_PER_CLK/2];
    rfdc_data_t normal_word;
    rfdc_data_t combined_word;

    // normal format, one sign-extended baseline-subtracted code per lane
    for (genvar i = 0; i < SAMPLES_PER_CLK; i++) begin : g_hgain
        logic [ADC_RESOLUTION-1:0] code;
        sample_t                   code_ext;
        assign code     = h_data[i*SAMPLE_WIDTH+SAMPLE_WIDTH-ADC_RESOLUTION +: ADC_RESOLUTION];
        assign code_ext = {{(SAMPLE_WIDTH-ADC_RESOLUTION){code[ADC_RESOLUTION-1]}}, code};
        assign h_sub[i] = code_ext - cfg_h_baseline;
        assign normal_word[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] = h_sub[i];
    end

    // averages of adjacent pairs, summed one bit wider so nothing overflows
    for (genvar i = 0; i < SAMPLES_PER_CLK/2; i++) begin : g_pair
        logic [SAMPLE_WIDTH:0] pair_sum;
        assign pair_sum    = {h_sub[2*i][SAMPLE_WIDTH-1], h_sub[2*i]}
                           + {h_sub[2*i+1][SAMPLE_WIDTH-1], h_sub[2*i+1]};
        assign pair_avg[i] = pair_sum[SAMPLE_WIDTH:1];
    end

    // each combined half carries one low-gain sample
    for (genvar i = 0; i < LGAIN_SAMPLES_PER_CLK; i++) begin : g_lgain
        sample_t l_sub;
        assign l_sub = l_data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH] - cfg_l_baseline;
        assign combined_word[i*HALF_W +: HALF_W] =
            {COMBINED_MARKER, pair_avg[2*i+1], pair_avg[2*i], l_sub};
    end

    logic [SAT_DW-1:0]  sat_delay_len;
    logic [CLR_DW-1:0]  clr_delay_len;
    logic [DATA_DW-1:0] data_delay_len;
    logic               core_trigger;
    logic               core_saturated;
    logic               sat_delayed;
    logic               ext_areset;
    logic               ext_set_config;
    rfdc_data_t         normal_delayed;
    rfdc_data_t         combined_delayed;
    timestamp_t         ts_delayed;
    logic               use_combined;
    trig_info_t         info;

    assign sat_delay_len  = SAT_DW'(cfg_pre_len);
    assign clr_delay_len  = CLR_DW'(cfg_pre_len) + CLR_DW'(CORE_CLR_LAT);
    assign data_delay_len = DATA_DW'(cfg_pre_len) + DATA_DW'(CORE_DATA_LAT);

    variable_shiftreg_delay #(.DATA_WIDTH(1), .MAX_DELAY(MAX_PRE_LEN)) sat_delay_inst (
        .ACLK(ACLK), .din(core_saturated), .delay(sat_delay_len), .dout(sat_delayed)
    );

    // the core is cleared again once the pre-window delay lines are full
    variable_shiftreg_delay #(.DATA_WIDTH(2), .MAX_DELAY(MAX_PRE_LEN+CORE_CLR_LAT)) clr_delay_inst (
        .ACLK(ACLK), .din({ARESET, set_config}), .delay(clr_delay_len),
        .dout({ext_areset, ext_set_config})
    );

    variable_shiftreg_delay #(
        .DATA_WIDTH($bits(rfdc_data_t)), .MAX_DELAY(MAX_PRE_LEN+CORE_DATA_LAT)
    ) normal_delay_inst (
        .ACLK(ACLK), .din(normal_word), .delay(data_delay_len), .dout(normal_delayed)
    );

    variable_shiftreg_delay #(
        .DATA_WIDTH($bits(rfdc_data_t)), .MAX_DELAY(MAX_PRE_LEN+CORE_DATA_LAT)
    ) combined_delay_inst (
        .ACLK(ACLK), .din(combined_word), .delay(data_delay_len), .dout(combined_delayed)
    );

    variable_shiftreg_delay #(
        .DATA_WIDTH($bits(timestamp_t)), .MAX_DELAY(MAX_PRE_LEN+CORE_DATA_LAT)
    ) ts_delay_inst (
        .ACLK(ACLK), .din(timestamp), .delay(data_delay_len), .dout(ts_delayed)
    );

    trigger_core #(.MAX_PRE_LEN(MAX_PRE_LEN), .MAX_POST_LEN(MAX_POST_LEN)) trigger_core_inst (
        .ACLK              (ACLK),
        .ARESET            (ARESET | ext_areset),
        .set_config        (set_config | ext_set_config),
        .stop              (stop),
        .dsp_data          (dsp_data),
        .h_data            (h_data),
        .stream_valid      (h_valid & l_valid & dsp_valid),
        .rising_threshold  (cfg_rising),
        .falling_threshold (cfg_falling),
        .pre_len           (cfg_pre_len),
        .post_len          (cfg_post_len),
        .trigger           (core_trigger),
        .saturated         (core_saturated)
    );

    // format select
    assign use_combined = cfg_acquire_mode | sat_delayed;

    always_comb begin
        info                  = '0;
        info[INFO_NORMAL_BIT] = ~use_combined;
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            event_data  <= '1;
            event_valid <= 1'b0;
        end else begin
            event_data  <= {use_combined ? combined_delayed : normal_delayed,
                            info, ts_delayed, trig_config};
            event_valid <= core_trigger;
        end
    end

    // copy for charge_sum, aligned with event_data
    always_ff @(posedge ACLK) begin
        h_gain_data <= normal_delayed;
    end

endmodule

// File: run.sh
#!/bin/bash
# build and run the testbench, then look for the failure verdict in the log
rm -rf obj_dir run.log
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_acq_channel -o sim_tb \
    && ./obj_dir/sim_tb > run.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }
grep -q "tests failed" run.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// File: tb.f
acq_pkg.sv
variable_shiftreg_delay.sv
trigger_core.sv
data_trigger.sv
charge_sum.sv
acq_channel.sv
acq_channel_asserts.sv
tb_acq_channel.sv

// File: tb_acq_channel.sv
module tb_acq_channel;
    timeunit 1ns;
    timeprecision 1ps;
    import acq_pkg::*;

    localparam int MAX_PRE  = 4;
    localparam int MAX_POST = 4;
    localparam int TIMEOUT  = 200;
    localparam int HIST     = 4096;

    logic ACLK = 1'b0;
    logic ARESET = 1'b1;
    logic set_config = 1'b0;
    logic stop = 1'b0;
    logic acquire_mode = 1'b0;
    rfdc_data_t h_data = '0;
    rfdc_data_t dsp_data = '0;
    lgain_data_t l_data = '0;
    logic h_valid = 1'b0;
    logic l_valid = 1'b0;
    logic dsp_valid = 1'b0;
    timestamp_t timestamp = '0;
    sample_t rising_threshold = '0;
    sample_t falling_threshold = '0;
    sample_t h_baseline = '0;
    sample_t l_baseline = '0;
    logic [$clog2(MAX_PRE):0] pre_len = '0;
    logic [$clog2(MAX_POST):0] post_len = '0;
    event_word_t event_data;
    logic event_valid;
    charge_t charge;
    logic charge_valid;

    // configuration as the DUT holds it
    logic m_mode = 1'b0;
    sample_t m_rise = sample_t'(1024);
    sample_t m_fall = sample_t'(1024);
    sample_t m_hbase = sample_t'(-1024);
    sample_t m_lbase = sample_t'(128);

    // driven words, indexed by timestamp
    rfdc_data_t hist_h [HIST];
    lgain_data_t hist_l [HIST];
    sample_t hist_hb [HIST];
    sample_t hist_lb [HIST];
    bit hist_sat [HIST];
    int rec_cyc [64];
    int rec_idx = 0;
    int cyc = 0;
    int errors = 0;
    int timeouts = 0;
    logic [15:0] lfsr = 16'd8;

    event_word_t word_q [$];
    bit got_valid = 0;
    bit charge_seen = 0;
    charge_t last_charge = '0;

    acq_channel #(.MAX_PRE_LEN(MAX_PRE), .MAX_POST_LEN(MAX_POST)) dut0 (.*);

    always #4 ACLK = ~ACLK;

    // outputs are settled at the falling edge
    always @(negedge ACLK) begin
        if (!ARESET && event_valid) begin
            word_q.push_back(event_data);
            got_valid = 1;
        end
        if (!ARESET && charge_valid) begin
            charge_seen = 1;
            last_charge = charge;
        end
    end

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic drive_cycle(input int dsp, input int lg0, input int lg1, input bit sat);
        rfdc_data_t h;
        int r;
        int code;
        int idx;
        @(posedge ACLK);
        // random codes stay within 64 of the baseline
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            r = take_bits(7);
            code = int'($signed(m_hbase)) + r - 64;
            if (sat && i == 0) code = 8191;
            h[i*16 +: 16] = {code[13:0], 2'b00};
        end
        idx = cyc % HIST;
        hist_h[idx]   = h;
        hist_l[idx]   = {lg1[15:0], lg0[15:0]};
        hist_hb[idx]  = m_hbase;
        hist_lb[idx]  = m_lbase;
        hist_sat[idx] = sat;
        ARESET     <= 1'b0;
        set_config <= 1'b0;
        stop       <= 1'b0;
        h_data     <= h;
        l_data     <= {lg1[15:0], lg0[15:0]};
        dsp_data   <= {SAMPLES_PER_CLK{sample_t'(dsp)}};
        h_valid    <= 1'b1;
        l_valid    <= 1'b1;
        dsp_valid  <= 1'b1;
        timestamp  <= timestamp_t'(cyc);
        cyc++;
    endtask

    function automatic int normal_lane(int ts, int i);
        int code;
        code = $signed(hist_h[ts % HIST][i*16+2 +: 14]);
        return code - int'($signed(hist_hb[ts % HIST]));
    endfunction

    function automatic event_word_t build_expected(int ts);
        rfdc_data_t data;
        sample_t avg [4];
        sample_t l_sub;
        trig_info_t info;
        bit comb;
        int s;
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            data[i*16 +: 16] = sample_t'(normal_lane(ts, i));
        end
        for (int j = 0; j < 4; j++) begin
            s = normal_lane(ts, 2*j) + normal_lane(ts, 2*j+1);
            avg[j] = sample_t'(s >>> 1);
        end
        // saturation is judged on the word itself
        comb = m_mode || hist_sat[ts % HIST];
        if (comb) begin
            for (int k = 0; k < 2; k++) begin
                l_sub = hist_l[ts % HIST][k*16 +: 16] - hist_lb[ts % HIST];
                data[k*64 +: 64] = {COMBINED_MARKER, avg[2*k+1], avg[2*k], l_sub};
            end
        end
        info    = '0;
        info[4] = !comb;
        return {data, info, timestamp_t'(ts), m_rise, m_fall};
    endfunction

    task automatic check_event(input string name, input event_word_t exp, input event_word_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_charge(input string name, input charge_t exp, input charge_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s charge: expected %0d actual %0d", name,
                     $signed(exp), $signed(act));
        end
    endtask

    task automatic check_config(input string name, input trig_config_t exp,
                                input trig_config_t act);
        if (exp !== act) begin
            errors++;
            $display("error %s config: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            errors++;
            $display("error %s word count: expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic expect_window(input string name, input int cnt, input int first);
        int waited;
        int sum;
        int ts;
        if (cnt == 0) begin
            repeat (20) drive_cycle(0, 0, 0, 0);
            check_count(name, 0, word_q.size());
        end else begin
            waited = 0;
            while (!got_valid && waited < TIMEOUT) begin
                drive_cycle(0, 0, 0, 0);
                waited++;
            end
            if (!got_valid) begin
                timeouts++;
                $display("timeout: test %s never raised event_valid", name);
            end
            waited = 0;
            while (!charge_seen && waited < TIMEOUT) begin
                drive_cycle(0, 0, 0, 0);
                waited++;
            end
            if (!charge_seen) begin
                timeouts++;
                $display("timeout: test %s never raised charge_valid", name);
            end
            check_count(name, cnt, word_q.size());
            sum = 0;
            for (int k = 0; k < cnt; k++) begin
                ts = rec_cyc[first] + k;
                if (k < word_q.size()) check_event(name, build_expected(ts), word_q[k]);
                for (int i = 0; i < SAMPLES_PER_CLK; i++) sum += normal_lane(ts, i);
            end
            check_charge(name, charge_t'(sum), last_charge);
        end
        word_q.delete();
        got_valid   = 0;
        charge_seen = 0;
    endtask

    initial begin
        int fd;
        int n;
        int v [7];
        string line;
        string kind;
        string name;
        repeat (2) begin
            drive_cycle(0, 0, 0, 0);
            ARESET <= 1'b1;
        end
        drive_cycle(0, 0, 0, 0);
        @(negedge ACLK);
        check_event("reset", '1, event_data);
        check_count("reset_valid", 0, int'(event_valid));
        repeat (8) drive_cycle(0, 0, 0, 0);
        @(negedge ACLK);
        check_config("reset", {sample_t'(1024), sample_t'(1024)}, event_data[31:0]);
        check_count("reset_idle", 0, word_q.size());
        fd = $fopen("acq_channel_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%s", kind);
                if (n < 1 || kind == "#") continue;
                if (kind == "C") begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %d", kind,
                                v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
                    drive_cycle(0, 0, 0, 0);
                    set_config        <= 1'b1;
                    acquire_mode      <= v[0][0];
                    pre_len           <= v[1][$clog2(MAX_PRE):0];
                    post_len          <= v[2][$clog2(MAX_POST):0];
                    rising_threshold  <= sample_t'(v[3]);
                    falling_threshold <= sample_t'(v[4]);
                    h_baseline        <= sample_t'(v[5]);
                    l_baseline        <= sample_t'(v[6]);
                    m_mode  = v[0][0];
                    m_rise  = sample_t'(v[3]);
                    m_fall  = sample_t'(v[4]);
                    m_hbase = sample_t'(v[5]);
                    m_lbase = sample_t'(v[6]);
                end else if (kind == "T") begin
                    drive_cycle(0, 0, 0, 0);
                    stop <= 1'b1;
                end else if (kind == "S") begin
                    n = $sscanf(line, "%s %s %d %d %d %d", kind, name, v[0], v[1], v[2], v[3]);
                    rec_cyc[rec_idx] = cyc;
                    rec_idx++;
                    drive_cycle(v[0], v[1], v[2], v[3][0]);
                end else if (kind == "E") begin
                    n = $sscanf(line, "%s %s %d %d", kind, name, v[0], v[1]);
                    expect_window(name, v[0], v[1]);
                    rec_idx = 0;
                end
            end
            $fclose(fd);
        end
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: trigger_core.sv
module trigger_core #(
    parameter int MAX_PRE_LEN  = 4,
    parameter int MAX_POST_LEN = 4
) (
    input  logic                          ACLK,
    input  logic                          ARESET,
    input  logic                          set_config,
    input  logic                          stop,
    input  acq_pkg::rfdc_data_t           dsp_data,
    input  acq_pkg::rfdc_data_t           h_data,
    input  logic                          stream_valid,
    input  acq_pkg::sample_t              rising_threshold,
    input  acq_pkg::sample_t              falling_threshold,
    input  logic [$clog2(MAX_PRE_LEN):0]  pre_len,
    input  logic [$clog2(MAX_POST_LEN):0] post_len,
    output logic                          trigger,
    output logic                          saturated
);
    import acq_pkg::*;

    localparam int CNT_W = $clog2(MAX_PRE_LEN + MAX_POST_LEN + 2);
    localparam logic [ADC_RESOLUTION-1:0] CODE_POS_FS = {1'b0, {(ADC_RESOLUTION-1){1'b1}}};
    localparam logic [ADC_RESOLUTION-1:0] CODE_NEG_FS = {1'b1, {(ADC_RESOLUTION-1){1'b0}}};

    core_state_t      state;
    logic             any_rise;
    logic             all_below;
    logic             any_full_scale;
    logic             valid_q;
    logic             rise_q;
    logic             below_q;
    logic             sat_cmp_q;
    logic             hit_q;
    logic             sat_hit_q;
    logic [CNT_W-1:0] window_len;
    logic [CNT_W-1:0] window_cnt;

    // per-word comparison of all lanes
    always_comb begin
        sample_t                   dsp_s;
        logic [ADC_RESOLUTION-1:0] h_code;
        any_rise       = 1'b0;
        all_below      = 1'b1;
        any_full_scale = 1'b0;
        for (int i = 0; i < SAMPLES_PER_CLK; i++) begin
            dsp_s  = dsp_data[i*SAMPLE_WIDTH +: SAMPLE_WIDTH];
            h_code = h_data[i*SAMPLE_WIDTH+SAMPLE_WIDTH-ADC_RESOLUTION +: ADC_RESOLUTION];
            if ($signed(dsp_s) >= $signed(rising_threshold)) begin
                any_rise = 1'b1;
            end
            if ($signed(dsp_s) >= $signed(falling_threshold)) begin
                all_below = 1'b0;
            end
            if (h_code == CODE_POS_FS || h_code == CODE_NEG_FS) begin
                any_full_scale = 1'b1;
            end
        end
    end

    // compare stage, then hit stage, then the registered saturation flag
    always_ff @(posedge ACLK) begin
        rise_q    <= any_rise;
        below_q   <= all_below;
        sat_cmp_q <= any_full_scale;
        sat_hit_q <= sat_cmp_q;
        saturated <= sat_hit_q;
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            valid_q <= 1'b0;
            hit_q   <= 1'b0;
        end else begin
            valid_q <= stream_valid;
            hit_q   <= valid_q && rise_q && state == ARMED && !stop;
        end
    end

    // holdoff waits for a quiet word so a level already above threshold does not fire
    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            state <= HOLDOFF;
        end else if (stop) begin
            state <= STOPPED;
        end else if (valid_q) begin
            case (state)
                HOLDOFF: begin
                    if (below_q) state <= ARMED;
                end
                ARMED: begin
                    if (rise_q) state <= FIRED;
                end
                FIRED: begin
                    // re-arm only once every lane has dropped below the falling threshold
                    if (below_q) state <= ARMED;
                end
                default: begin
                    state <= STOPPED;
                end
            endcase
        end
    end

    // window covers pre words before the hit, the hit itself and post words after
    assign window_len = CNT_W'(pre_len) + CNT_W'(post_len) + CNT_W'(1);

    always_ff @(posedge ACLK) begin
        if (ARESET || set_config) begin
            window_cnt <= '0;
        end else if (hit_q) begin
            window_cnt <= window_len;
        end else if (window_cnt != '0) begin
            window_cnt <= window_cnt - 1'b1;
        end
    end

    assign trigger = (window_cnt != '0);

endmodule

// File: variable_shiftreg_delay.sv
module variable_shiftreg_delay #(
    parameter int DATA_WIDTH = 1,
    parameter int MAX_DELAY  = 4
) (
    input  logic                           ACLK,
    input  logic [DATA_WIDTH-1:0]          din,
    input  logic [$clog2(MAX_DELAY+1)-1:0] delay,
    output logic [DATA_WIDTH-1:0]          dout
);

    // stage i holds the input of i+1 cycles ago
    logic [DATA_WIDTH-1:0] stages [MAX_DELAY];

    always_ff @(posedge ACLK) begin
        stages[0] <= din;
        for (int i = 1; i < MAX_DELAY; i++) begin
            stages[i] <= stages[i-1];
        end
    end

    // zero delay bypasses the chain, anything past the end takes the last stage
    always_comb begin
        if (delay == '0) begin
            dout = din;
        end else if (delay > MAX_DELAY) begin
            dout = stages[MAX_DELAY-1];
        end else begin
            dout = stages[delay-1];
        end
    end

endmodule
